// File: Bender.yml
package:
  name: mci

sources:
  - files:
      - hdl/mci_pkg.sv
      - hdl/mci_csr.sv
      - hdl/mci_boot_seq.sv
      - hdl/mci_wdt.sv
      - hdl/mci_top.sv
  - target: test
    files:
      - verif/mci_clk_gen.sv
      - verif/mci_props.sv
      - verif/mci_tb.sv

// File: hdl/mci_boot_seq.sv
// Boot sequencer. Lifecycle and fuse init are handshakes with no timeout
module mci_boot_seq import mci_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  csr_ctrl_t    csr_ctrl_i,
    input  logic         lc_done_i,
    output logic         lc_init_o,
    input  logic         fc_done_i,
    output logic         fc_init_o,
    output logic         mcu_rst_b_o,
    output boot_status_t boot_status_o
);

    boot_state_e          state_q;
    boot_state_e          state_d;
    logic [RST_CNT_W-1:0] hold_cnt_q;
    logic                 hold_done;
    logic                 once_q;

    // Last cycle of the firmware reset hold
    assign hold_done = (hold_cnt_q == RST_CNT_W'(RST_HOLD_CYCLES - 1));

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            BOOT_IDLE: begin
                state_d = BOOT_LC_INIT;
            end
            BOOT_LC_INIT: begin
                if (lc_done_i) begin
                    state_d = BOOT_FC_INIT;
                end
            end
            BOOT_FC_INIT: begin
                if (fc_done_i) begin
                    state_d = BOOT_WAIT_GO;
                end
            end
            BOOT_WAIT_GO: begin
                if (csr_ctrl_i.boot_go) begin
                    state_d = BOOT_MCU_RUN;
                end
            end
            BOOT_MCU_RUN: begin
                // Requests outside the run state are dropped
                if (csr_ctrl_i.mcu_rst_req) begin
                    state_d = BOOT_MCU_RST;
                end
            end
            BOOT_MCU_RST: begin
                if (hold_done) begin
                    state_d = BOOT_MCU_RUN;
                end
            end
            default: begin
                state_d = BOOT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= BOOT_IDLE;
            hold_cnt_q <= '0;
            once_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == BOOT_MCU_RST && !hold_done) begin
                hold_cnt_q <= hold_cnt_q + 1'b1;
            end else begin
                hold_cnt_q <= '0;
            end
            // Stays set until the next core reset
            if (state_d == BOOT_MCU_RST) begin
                once_q <= 1'b1;
            end
        end
    end

    // Outputs decoded from the state
    assign lc_init_o   = (state_q == BOOT_LC_INIT);
    assign fc_init_o   = (state_q == BOOT_FC_INIT);
    assign mcu_rst_b_o = (state_q == BOOT_MCU_RUN);

    assign boot_status_o.state          = state_q;
    assign boot_status_o.mcu_reset_once = once_q;

endmodule

// File: hdl/mci_csr.sv
// APB register bank with zero wait states. Unmapped offsets and boot status writes raise pslverr
module mci_csr import mci_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  apb_req_t          apb_req_i,
    output apb_rsp_t          apb_rsp_o,
    input  logic [DATA_W-1:0] strap_reset_vector_i,
    input  boot_status_t      boot_status_i,
    input  wdt_event_t        wdt_event_i,
    output csr_ctrl_t         csr_ctrl_o,
    output logic [DATA_W-1:0] mcu_reset_vector_o,
    output logic              mci_intr_o,
    output logic              nmi_o
);

    logic              access;
    logic              wr_en;
    logic              wr_ro;
    logic              addr_hit;
    logic [DATA_W-1:0] rd_mux;

    // Per-register write strobes
    logic we_boot_go;
    logic we_rst_req;
    logic we_wdt_en;
    logic we_wdt_restart;
    logic we_period1;
    logic we_period2;
    logic we_wdt_status;
    logic we_rst_vec;

    logic              boot_go_q;
    logic              rst_req_q;
    logic              wdt_en_q;
    logic              wdt_restart_q;
    logic [DATA_W-1:0] period1_q;
    logic [DATA_W-1:0] period2_q;
    logic [DATA_W-1:0] rst_vec_q;
    logic              rst_vec_wr_q;
    logic              t1_sts_q;
    logic              t2_sts_q;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    assign access = apb_req_i.psel & apb_req_i.penable;
    assign wr_en  = access & apb_req_i.pwrite;
    assign wr_ro  = apb_req_i.pwrite & (apb_req_i.paddr == ADDR_BOOT_STATUS);

    assign we_boot_go     = wr_en & (apb_req_i.paddr == ADDR_BOOT_GO);
    assign we_rst_req     = wr_en & (apb_req_i.paddr == ADDR_RESET_REQ);
    assign we_wdt_en      = wr_en & (apb_req_i.paddr == ADDR_WDT_EN);
    assign we_wdt_restart = wr_en & (apb_req_i.paddr == ADDR_WDT_RESTART);
    assign we_period1     = wr_en & (apb_req_i.paddr == ADDR_WDT_PERIOD1);
    assign we_period2     = wr_en & (apb_req_i.paddr == ADDR_WDT_PERIOD2);
    assign we_wdt_status  = wr_en & (apb_req_i.paddr == ADDR_WDT_STATUS);
    assign we_rst_vec     = wr_en & (apb_req_i.paddr == ADDR_RESET_VECTOR);

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            boot_go_q     <= 1'b0;
            rst_req_q     <= 1'b0;
            wdt_en_q      <= 1'b0;
            wdt_restart_q <= 1'b0;
            period1_q     <= '1;
            period2_q     <= '1;
            rst_vec_wr_q  <= 1'b0;
            t1_sts_q      <= 1'b0;
            t2_sts_q      <= 1'b0;
        end else begin
            if (we_boot_go) begin
                boot_go_q <= apb_req_i.pwdata[0];
            end
            if (we_wdt_en) begin
                wdt_en_q <= apb_req_i.pwdata[0];
            end
            if (we_period1) begin
                period1_q <= apb_req_i.pwdata;
            end
            if (we_period2) begin
                period2_q <= apb_req_i.pwdata;
            end
            if (we_rst_vec) begin
                rst_vec_wr_q <= 1'b1;
            end
            // Request pulses last one cycle after the write edge
            rst_req_q     <= we_rst_req & apb_req_i.pwdata[0];
            wdt_restart_q <= we_wdt_restart & apb_req_i.pwdata[0];
            // Sticky W1C status, a new expiry beats a clear
            t1_sts_q <= wdt_event_i.t1_expire_p |
                        (t1_sts_q & ~(we_wdt_status & apb_req_i.pwdata[0]));
            t2_sts_q <= wdt_event_i.t2_expire_p |
                        (t2_sts_q & ~(we_wdt_status & apb_req_i.pwdata[1]));
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_rst_vec) begin
            rst_vec_q <= apb_req_i.pwdata;
        end
    end

    // Strap value until firmware writes its own vector
    assign mcu_reset_vector_o = rst_vec_wr_q ? rst_vec_q : strap_reset_vector_i;

    ////////////////////////////////////////////////////////////////////////////
    // Read mux and response
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        addr_hit = 1'b1;
        rd_mux   = '0;
        case (apb_req_i.paddr)
            ADDR_BOOT_GO:      rd_mux[0] = boot_go_q;
            ADDR_RESET_REQ:    rd_mux    = '0;
            ADDR_WDT_EN:       rd_mux[0] = wdt_en_q;
            ADDR_WDT_RESTART:  rd_mux    = '0;
            ADDR_WDT_PERIOD1:  rd_mux    = period1_q;
            ADDR_WDT_PERIOD2:  rd_mux    = period2_q;
            ADDR_WDT_STATUS:   rd_mux[1:0] = {t2_sts_q, t1_sts_q};
            ADDR_BOOT_STATUS: begin
                rd_mux[2:0]               = boot_status_i.state;
                rd_mux[BOOT_STS_ONCE_BIT] = boot_status_i.mcu_reset_once;
            end
            ADDR_RESET_VECTOR: rd_mux    = mcu_reset_vector_o;
            default:           addr_hit  = 1'b0;
        endcase
    end

    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = access & (~addr_hit | wr_ro);
    assign apb_rsp_o.prdata  = (access & ~apb_req_i.pwrite) ? rd_mux : '0;

    assign csr_ctrl_o.boot_go     = boot_go_q;
    assign csr_ctrl_o.mcu_rst_req = rst_req_q;
    assign csr_ctrl_o.wdt_en      = wdt_en_q;
    assign csr_ctrl_o.wdt_restart = wdt_restart_q;
    assign csr_ctrl_o.wdt_period1 = period1_q;
    assign csr_ctrl_o.wdt_period2 = period2_q;

    // Timer 1 interrupts the MCU, timer 2 escalates to NMI
    assign mci_intr_o = t1_sts_q;
    assign nmi_o      = t2_sts_q;

endmodule

// File: hdl/mci_pkg.sv
// Sizes, register map and shared types for the management core. Every register is 32 bits wide
package mci_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned DATA_W          = 32;
    localparam int unsigned ADDR_W          = 12;

    // MCU reset hold for a firmware request
    localparam int unsigned RST_HOLD_CYCLES = 16;
    localparam int unsigned RST_CNT_W       = 5;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [ADDR_W-1:0] ADDR_BOOT_GO      = 12'h000;
    localparam logic [ADDR_W-1:0] ADDR_RESET_REQ    = 12'h004;
    localparam logic [ADDR_W-1:0] ADDR_WDT_EN       = 12'h008;
    localparam logic [ADDR_W-1:0] ADDR_WDT_RESTART  = 12'h00C;
    localparam logic [ADDR_W-1:0] ADDR_WDT_PERIOD1  = 12'h010;
    localparam logic [ADDR_W-1:0] ADDR_WDT_PERIOD2  = 12'h014;
    localparam logic [ADDR_W-1:0] ADDR_WDT_STATUS   = 12'h018;
    localparam logic [ADDR_W-1:0] ADDR_BOOT_STATUS  = 12'h01C;
    localparam logic [ADDR_W-1:0] ADDR_RESET_VECTOR = 12'h020;

    // Position of the reset-once flag in the boot status word
    localparam int unsigned BOOT_STS_ONCE_BIT = 8;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        BOOT_IDLE    = 3'd0,
        BOOT_LC_INIT = 3'd1,
        BOOT_FC_INIT = 3'd2,
        BOOT_WAIT_GO = 3'd3,
        BOOT_MCU_RUN = 3'd4,
        BOOT_MCU_RST = 3'd5
    } boot_state_e;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // Configuration and one-cycle requests from the register bank
    typedef struct packed {
        logic              boot_go;
        logic              mcu_rst_req;
        logic              wdt_en;
        logic              wdt_restart;
        logic [DATA_W-1:0] wdt_period1;
        logic [DATA_W-1:0] wdt_period2;
    } csr_ctrl_t;

    typedef struct packed {
        logic t1_expire_p;
        logic t2_expire_p;
    } wdt_event_t;

    typedef struct packed {
        boot_state_e state;
        logic        mcu_reset_once;
    } boot_status_t;

endpackage

// File: hdl/mci_top.sv
// Management core top. The MCU stays in reset until lifecycle and fuse init finish and boot go is set
module mci_top import mci_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  apb_req_t          apb_req_i,
    output apb_rsp_t          apb_rsp_o,
    input  logic              lc_done_i,
    output logic              lc_init_o,
    input  logic              fc_done_i,
    output logic              fc_init_o,
    input  logic [DATA_W-1:0] strap_reset_vector_i,
    output logic              mcu_rst_b_o,
    output logic [DATA_W-1:0] mcu_reset_vector_o,
    output logic              mci_intr_o,
    output logic              nmi_o
);

    csr_ctrl_t    csr_ctrl;
    wdt_event_t   wdt_event;
    boot_status_t boot_status;

    // Register bank
    mci_csr u_csr (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .apb_req_i            (apb_req_i),
        .apb_rsp_o            (apb_rsp_o),
        .strap_reset_vector_i (strap_reset_vector_i),
        .boot_status_i        (boot_status),
        .wdt_event_i          (wdt_event),
        .csr_ctrl_o           (csr_ctrl),
        .mcu_reset_vector_o   (mcu_reset_vector_o),
        .mci_intr_o           (mci_intr_o),
        .nmi_o                (nmi_o)
    );

    // Boot and MCU reset control
    mci_boot_seq u_boot_seq (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .csr_ctrl_i    (csr_ctrl),
        .lc_done_i     (lc_done_i),
        .lc_init_o     (lc_init_o),
        .fc_done_i     (fc_done_i),
        .fc_init_o     (fc_init_o),
        .mcu_rst_b_o   (mcu_rst_b_o),
        .boot_status_o (boot_status)
    );

    // Watchdog
    mci_wdt u_wdt (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .csr_ctrl_i  (csr_ctrl),
        .wdt_event_o (wdt_event)
    );

endmodule

// File: hdl/mci_wdt.sv
// Two-stage watchdog. Timer 2 runs only after timer 1 expires and stops at its own expiry
module mci_wdt import mci_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  csr_ctrl_t  csr_ctrl_i,
    output wdt_event_t wdt_event_o
);

    logic [DATA_W-1:0] t1_cnt_q;
    logic [DATA_W-1:0] t2_cnt_q;
    logic              stage2_q;
    logic              stopped_q;
    logic              t1_p_q;
    logic              t2_p_q;

    logic clear;
    logic t1_run;
    logic t2_run;
    logic t1_hit;
    logic t2_hit;

    // Restart or disable drops both stages
    assign clear  = csr_ctrl_i.wdt_restart | ~csr_ctrl_i.wdt_en;
    assign t1_run = ~clear & ~stage2_q;
    assign t2_run = ~clear & stage2_q & ~stopped_q;
    assign t1_hit = t1_run & (t1_cnt_q == csr_ctrl_i.wdt_period1);
    assign t2_hit = t2_run & (t2_cnt_q == csr_ctrl_i.wdt_period2);

    ////////////////////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            t1_cnt_q  <= '0;
            t2_cnt_q  <= '0;
            stage2_q  <= 1'b0;
            stopped_q <= 1'b0;
        end else if (clear) begin
            t1_cnt_q  <= '0;
            t2_cnt_q  <= '0;
            stage2_q  <= 1'b0;
            stopped_q <= 1'b0;
        end else if (t1_hit) begin
            // Hand over to the second stage
            t1_cnt_q <= '0;
            stage2_q <= 1'b1;
        end else if (t1_run) begin
            t1_cnt_q <= t1_cnt_q + 1'b1;
        end else if (t2_hit) begin
            stopped_q <= 1'b1;
        end else if (t2_run) begin
            t2_cnt_q <= t2_cnt_q + 1'b1;
        end
    end

    // Expiry pulses, one cycle each
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            t1_p_q <= 1'b0;
            t2_p_q <= 1'b0;
        end else begin
            t1_p_q <= t1_hit;
            t2_p_q <= t2_hit;
        end
    end

    assign wdt_event_o.t1_expire_p = t1_p_q;
    assign wdt_event_o.t2_expire_p = t2_p_q;

endmodule

// File: sim.f
hdl/mci_pkg.sv
hdl/mci_csr.sv
hdl/mci_boot_seq.sv
hdl/mci_wdt.sv
hdl/mci_top.sv
verif/mci_clk_gen.sv
verif/mci_props.sv
verif/mci_tb.sv

// File: verif/mci_clk_gen.sv
// Free-running clock of period 10 with an active-low reset held for the first two cycles
module mci_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

    always #5 clk_o = ~clk_o;

endmodule

// File: verif/mci_props.sv
// Port-level checks on mci_top. Watchdog windows assume period 1 is written before the enable
module mci_props import mci_pkg::*; (
    input logic     clk_i,
    input logic     rst_n_i,
    input apb_req_t apb_req_i,
    input apb_rsp_t apb_rsp_o,
    input logic     lc_done_i,
    input logic     lc_init_o,
    input logic     fc_init_o,
    input logic     mcu_rst_b_o,
    input logic     mci_intr_o,
    input logic     nmi_o
);

    int                fail_cnt = 0;
    logic              access;
    logic              wr_fire;
    logic              exp_err;
    logic              lc_seen_q;
    logic              go_seen_q;
    logic              wdt_en_q;
    logic              armed_q;
    logic [DATA_W-1:0] period1_q;
    logic [DATA_W:0]   win_cnt_q;

    function automatic void note_failure(input string what);
        $error("%s", what);
        fail_cnt++;
    endfunction

    assign access  = apb_req_i.psel && apb_req_i.penable;
    assign wr_fire = access && apb_req_i.pwrite;
    // Nine word registers from 0x00 to 0x20 and a read-only boot status
    assign exp_err = (apb_req_i.paddr > ADDR_RESET_VECTOR) || (apb_req_i.paddr[1:0] != 2'b00) ||
                     (apb_req_i.pwrite && apb_req_i.paddr == ADDR_BOOT_STATUS);

    ////////////////////////////////////////////////////////////////////////////
    // Reference state seen from the ports
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lc_seen_q <= 1'b0;
            go_seen_q <= 1'b0;
            wdt_en_q  <= 1'b0;
            armed_q   <= 1'b0;
            period1_q <= '1;
            win_cnt_q <= '0;
        end else begin
            if (lc_init_o && lc_done_i) begin
                lc_seen_q <= 1'b1;
            end
            if (wr_fire && apb_req_i.paddr == ADDR_BOOT_GO && apb_req_i.pwdata[0]) begin
                go_seen_q <= 1'b1;
            end
            if (wr_fire && apb_req_i.paddr == ADDR_WDT_PERIOD1) begin
                period1_q <= apb_req_i.pwdata;
            end
            if (wr_fire && apb_req_i.paddr == ADDR_WDT_EN) begin
                wdt_en_q <= apb_req_i.pwdata[0];
            end
            // Expiry window opens at each enable or restart write
            if (wr_fire && apb_req_i.pwdata[0] && !mci_intr_o &&
                (apb_req_i.paddr == ADDR_WDT_EN ||
                 (apb_req_i.paddr == ADDR_WDT_RESTART && wdt_en_q))) begin
                armed_q   <= 1'b1;
                win_cnt_q <= '0;
            end else if (mci_intr_o || (wr_fire && apb_req_i.paddr == ADDR_WDT_EN)) begin
                armed_q <= 1'b0;
            end else if (armed_q) begin
                win_cnt_q <= win_cnt_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////////////////////

    a_init_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(lc_init_o && fc_init_o))
        else note_failure("lc_init_o and fc_init_o are high together");

    a_fc_after_lc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fc_init_o |-> lc_seen_q)
        else note_failure("fc_init_o is high before lc_done_i was seen");

    a_run_after_go: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mcu_rst_b_o |-> go_seen_q)
        else note_failure("mcu_rst_b_o is high before boot go was written");

    a_pready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        access |-> apb_rsp_o.pready)
        else note_failure("pready is low in an access cycle");

    a_pslverr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        access |-> apb_rsp_o.pslverr == exp_err)
        else note_failure("pslverr does not match the register map");

    a_rst_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(mcu_rst_b_o) |-> !mcu_rst_b_o [*RST_HOLD_CYCLES] ##1 mcu_rst_b_o)
        else note_failure("MCU reset hold has the wrong length");

    a_intr_not_early: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        armed_q && (win_cnt_q < {1'b0, period1_q}) |-> !mci_intr_o)
        else note_failure("mci_intr_o rose before period 1 ran out");

    a_intr_in_time: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        armed_q && !mci_intr_o |-> win_cnt_q <= {1'b0, period1_q} + 33'd2)
        else note_failure("mci_intr_o did not rise within period 1 plus 3 cycles");

    a_nmi_after_intr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(nmi_o) |-> mci_intr_o)
        else note_failure("nmi_o rose while mci_intr_o was low");

endmodule

bind mci_top mci_props u_props (.*);

// File: verif/mci_tb.sv
// Directed testbench for mci_top. Lifecycle and fuse models answer 1 to 8 cycles after init
module mci_tb import mci_pkg::*; ();

    localparam logic [DATA_W-1:0] STRAP_VEC = 32'h0000_8000;
    localparam int WDT_P1 = 20;
    localparam int WDT_P2 = 30;
    // Cycle bound of each test, the run limit adds margin to their sum
    localparam int BOOT_BOUND     = 150;
    localparam int REG_BOUND      = 250;
    localparam int RST_BOUND      = 150;
    localparam int WDT_BOUND      = 450;
    localparam int TIMEOUT_CYCLES = 4 * (BOOT_BOUND + REG_BOUND + RST_BOUND + WDT_BOUND);

    logic              clk;
    logic              rst_n;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;
    logic              lc_done;
    logic              lc_init;
    logic              fc_done;
    logic              fc_init;
    logic [DATA_W-1:0] strap_vec;
    logic              mcu_rst_b;
    logic [DATA_W-1:0] mcu_vec;
    logic              intr;
    logic              nmi;

    integer seed;
    int     err_cnt;
    int     test_cnt;
    int     fails_before;
    int     lc_delay;
    int     fc_delay;

    mci_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mci_top dut_i (
        .clk_i                (clk),
        .rst_n_i              (rst_n),
        .apb_req_i            (apb_req),
        .apb_rsp_o            (apb_rsp),
        .lc_done_i            (lc_done),
        .lc_init_o            (lc_init),
        .fc_done_i            (fc_done),
        .fc_init_o            (fc_init),
        .strap_reset_vector_i (strap_vec),
        .mcu_rst_b_o          (mcu_rst_b),
        .mcu_reset_vector_o   (mcu_vec),
        .mci_intr_o           (intr),
        .nmi_o                (nmi)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Lifecycle and fuse controller models
    ////////////////////////////////////////////////////////////////////////////

    always begin
        @(negedge clk);
        if (lc_init && !lc_done) begin
            lc_delay = 1 + ($unsigned($random(seed)) % 8);
            repeat (lc_delay) @(posedge clk);
            lc_done <= 1'b1;
            @(posedge clk);
            lc_done <= 1'b0;
        end
    end

    always begin
        @(negedge clk);
        if (fc_init && !fc_done) begin
            fc_delay = 1 + ($unsigned($random(seed)) % 8);
            repeat (fc_delay) @(posedge clk);
            fc_done <= 1'b1;
            @(posedge clk);
            fc_done <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // APB and helper tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        // Mid access cycle, response is stable
        @(negedge clk);
        rdata = apb_rsp.prdata;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        apb_xfer(1'b0, addr, '0, data);
    endtask

    task automatic expect_reg(input string name, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] exp);
        logic [DATA_W-1:0] got;
        apb_read(addr, got);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic wait_boot_state(input boot_state_e target, input int max_polls);
        logic [DATA_W-1:0] sts;
        int                polls;
        polls = 0;
        apb_read(ADDR_BOOT_STATUS, sts);
        while (sts[2:0] != target && polls < max_polls) begin
            apb_read(ADDR_BOOT_STATUS, sts);
            polls++;
        end
        if (sts[2:0] != target) begin
            $display("Boot sequencer did not reach %s in %0d reads", target.name(), max_polls);
            err_cnt++;
        end
    endtask

    task automatic wait_output(input string name, input logic level, input int max_cycles);
        logic v;
        int   n;
        n = 0;
        v = ~level;
        while (v !== level && n < max_cycles) begin
            @(negedge clk);
            case (name)
                "mcu_rst_b_o": v = mcu_rst_b;
                "mci_intr_o":  v = intr;
                default:       v = nmi;
            endcase
            n++;
        end
        if (v !== level) begin
            $display("%s did not go to %0b within %0d cycles", name, level, max_cycles);
            err_cnt++;
        end
    endtask

    function automatic int fail_total();
        return err_cnt + dut_i.u_props.fail_cnt;
    endfunction

    task automatic end_test(input string name);
        test_cnt++;
        $display("test %0d %s: %s", test_cnt, name,
                 (fail_total() > fails_before) ? "failed" : "ok");
        fails_before = fail_total();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [DATA_W-1:0] val;
        seed         = 32'hbb994e10;
        err_cnt      = 0;
        test_cnt     = 0;
        fails_before = 0;
        apb_req      = '0;
        lc_done      = 1'b0;
        fc_done      = 1'b0;
        strap_vec    = STRAP_VEC;
        wait (rst_n === 1'b1);

        expect_reg("RESET_VECTOR", ADDR_RESET_VECTOR, STRAP_VEC);
        end_test("strap vector");

        wait_boot_state(BOOT_WAIT_GO, 40);
        apb_write(ADDR_BOOT_GO, 32'h1);
        wait_output("mcu_rst_b_o", 1'b1, 20);
        expect_reg("BOOT_STATUS", ADDR_BOOT_STATUS, 32'(BOOT_MCU_RUN));
        expect_reg("BOOT_GO", ADDR_BOOT_GO, 32'h1);
        end_test("boot order");

        val = $random(seed);
        apb_write(ADDR_WDT_PERIOD1, val);
        expect_reg("WDT_PERIOD1", ADDR_WDT_PERIOD1, val);
        val = $random(seed);
        apb_write(ADDR_WDT_PERIOD2, val);
        expect_reg("WDT_PERIOD2", ADDR_WDT_PERIOD2, val);
        val = $random(seed);
        apb_write(ADDR_RESET_VECTOR, val);
        expect_reg("RESET_VECTOR", ADDR_RESET_VECTOR, val);
        @(negedge clk);
        if (mcu_vec !== val) begin
            $display("** Error at %0t: mcu_reset_vector_o expected 0x%08h, got 0x%08h",
                     $time, val, mcu_vec);
            err_cnt++;
        end
        end_test("register read-back");

        // Unmapped, unaligned and read-only accesses among legal ones
        expect_reg("unmapped 0x024", 12'h024, '0);
        expect_reg("unaligned 0x002", 12'h002, '0);
        apb_write(12'hFFC, 32'hFFFF_FFFF);
        apb_write(ADDR_BOOT_STATUS, 32'hFFFF_FFFF);
        expect_reg("BOOT_STATUS", ADDR_BOOT_STATUS, 32'(BOOT_MCU_RUN));
        expect_reg("RESET_REQ", ADDR_RESET_REQ, '0);
        end_test("APB errors");

        apb_write(ADDR_RESET_REQ, 32'h1);
        wait_output("mcu_rst_b_o", 1'b0, 5);
        wait_output("mcu_rst_b_o", 1'b1, RST_HOLD_CYCLES + 5);
        // Reset-once flag sits in bit 8
        expect_reg("BOOT_STATUS", ADDR_BOOT_STATUS, 32'h100 | 32'(BOOT_MCU_RUN));
        end_test("MCU reset request");

        apb_write(ADDR_WDT_PERIOD1, WDT_P1);
        apb_write(ADDR_WDT_PERIOD2, WDT_P2);
        apb_write(ADDR_WDT_EN, 32'h1);
        // Service the watchdog well inside period 1
        repeat (6) begin
            repeat (WDT_P1 / 4) @(posedge clk);
            apb_write(ADDR_WDT_RESTART, 32'h1);
        end
        expect_reg("WDT_STATUS", ADDR_WDT_STATUS, '0);
        end_test("watchdog restart");

        wait_output("mci_intr_o", 1'b1, WDT_P1 + 10);
        wait_output("nmi_o", 1'b1, WDT_P2 + 10);
        expect_reg("WDT_STATUS", ADDR_WDT_STATUS, 32'h3);
        apb_write(ADDR_WDT_EN, 32'h0);
        apb_write(ADDR_WDT_STATUS, 32'h3);
        expect_reg("WDT_STATUS", ADDR_WDT_STATUS, '0);
        end_test("watchdog escalation");

        repeat (4) @(posedge clk);
        $display("%0d tests run, %0d failed checks", test_cnt, fail_total());
        if (fail_total() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Run limit
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule
